// File: common/pmem_cfg_pkg.sv
package pmem_cfg_pkg;

	// four ingress and four egress interfaces
	localparam int num_iface = 4;
	localparam int iface_w = 2;

	// one beat on the stream
	localparam int data_w = 64;
	// unused bytes in the last beat
	localparam int empty_w = 3;

	// packet store, 256 beats per input
	localparam int addr_w = 8;
	localparam int store_depth = 1 << addr_w;

	// packet tags wrap at 64
	localparam int tag_w = 6;
	localparam int tag_depth = 1 << tag_w;

	// packet length in beats
	localparam int len_w = 6;

	// per-output command queue
	localparam int cmdq_depth = 8;
	localparam int cmdq_ptr_w = $clog2(cmdq_depth);

endpackage

// File: common/pmem_cmd_pkg.sv
package pmem_cmd_pkg;

	// descriptor is {empty, start address, length}
	localparam int desc_len_lsb = 0;
	localparam int desc_addr_lsb = desc_len_lsb + pmem_cfg_pkg::len_w;
	localparam int desc_empty_lsb = desc_addr_lsb + pmem_cfg_pkg::addr_w;
	localparam int desc_w = desc_empty_lsb + pmem_cfg_pkg::empty_w;

	// command is {input index, descriptor}
	localparam int cmd_in_lsb = desc_w;
	localparam int cmd_w = cmd_in_lsb + pmem_cfg_pkg::iface_w;

	// match result, top down: output, input, tag
	localparam int match_tag_lsb = 0;
	localparam int match_in_lsb = match_tag_lsb + pmem_cfg_pkg::tag_w;
	localparam int match_out_lsb = match_in_lsb + pmem_cfg_pkg::iface_w;
	localparam int match_w = match_out_lsb + pmem_cfg_pkg::iface_w;

	// egress reader states
	typedef enum logic [1:0] {
		idle,
		load,
		stream
	} egress_state_t;

endpackage

// File: source/ingress_tagger.sv
`timescale 1ns/10ps

module ingress_tagger (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	input  logic in_ready,
	input  logic in_sop,
	input  logic in_eop,
	input  logic [pmem_cfg_pkg::empty_w-1:0] in_empty,
	output logic [pmem_cfg_pkg::tag_w-1:0] tag,
	output logic wr_en,
	output logic [pmem_cfg_pkg::addr_w-1:0] wr_addr,
	output logic desc_wr,
	output logic [pmem_cmd_pkg::desc_w-1:0] desc_data
);

	logic accept;
	// first address of the open packet
	logic [pmem_cfg_pkg::addr_w-1:0] start_q;
	logic [pmem_cfg_pkg::addr_w-1:0] start_cur;
	// beats taken so far in the open packet
	logic [pmem_cfg_pkg::len_w-1:0] len_q;
	logic [pmem_cfg_pkg::len_w-1:0] len_cur;
	// a sop has been seen without its eop
	logic in_packet;

	assign accept = in_valid && in_ready;

	// store write in the cycle of the beat
	assign wr_en = accept;

	// a single beat packet starts at the current address
	assign start_cur = in_sop ? wr_addr : start_q;
	// length including this beat
	assign len_cur = (in_sop ? '0 : len_q) + 1'b1;

	// descriptor goes to the table on eop, at the current tag
	assign desc_wr = accept && in_eop;
	assign desc_data = {in_empty, start_cur, len_cur};

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_addr <= '0;
			start_q <= '0;
			len_q <= '0;
			tag <= '0;
			in_packet <= 1'b0;
		end else if (accept) begin
			// address wraps at the store size
			wr_addr <= wr_addr + 1'b1;
			len_q <= in_eop ? '0 : len_cur;
			if (in_sop) begin
				start_q <= wr_addr;
			end
			// next packet gets the next tag
			if (in_eop) begin
				tag <= tag + 1'b1;
			end
			in_packet <= !in_eop;
		end
	end

	// eop without a sop before it would write a bogus descriptor
	a_eop_in_packet: assert property (@(posedge clock) disable iff (reset)
		(accept && in_eop && !in_sop) |-> in_packet);

endmodule

// File: packet_buffer/packet_store.sv
`timescale 1ns/10ps

module packet_store (
	input  logic clock,
	input  logic wr_en,
	input  logic [pmem_cfg_pkg::addr_w-1:0] wr_addr,
	input  logic [pmem_cfg_pkg::data_w-1:0] wr_data,
	input  logic [pmem_cfg_pkg::addr_w-1:0] rd_addr [pmem_cfg_pkg::num_iface],
	output logic [pmem_cfg_pkg::data_w-1:0] rd_data [pmem_cfg_pkg::num_iface]
);

	// beats of one input, written in arrival order
	logic [pmem_cfg_pkg::data_w-1:0] mem [pmem_cfg_pkg::store_depth];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// one combinational read port per output
	always_comb begin
		for (int i = 0; i < pmem_cfg_pkg::num_iface; i++) begin
			rd_data[i] = mem[rd_addr[i]];
		end
	end

endmodule

// File: packet_buffer/packet_table.sv
`timescale 1ns/10ps

module packet_table (
	input  logic clock,
	input  logic wr_en,
	input  logic [pmem_cfg_pkg::tag_w-1:0] wr_tag,
	input  logic [pmem_cmd_pkg::desc_w-1:0] wr_desc,
	input  logic [pmem_cfg_pkg::tag_w-1:0] rd_tag,
	output logic [pmem_cmd_pkg::desc_w-1:0] rd_desc
);

	// one descriptor per tag
	logic [pmem_cmd_pkg::desc_w-1:0] mem [pmem_cfg_pkg::tag_depth];

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_tag] <= wr_desc;
		end
	end

	// registered read, descriptor shows up one clock after the tag
	always_ff @(posedge clock) begin
		rd_desc <= mem[rd_tag];
	end

endmodule

// File: dispatch/match_dispatch.sv
`timescale 1ns/10ps

module match_dispatch (
	input  logic clock,
	input  logic reset,
	input  logic [pmem_cmd_pkg::match_w-1:0] tagin_data,
	input  logic tagin_valid,
	output logic tagin_ready,
	output logic [pmem_cfg_pkg::tag_w-1:0] rd_tag,
	input  logic [pmem_cmd_pkg::desc_w-1:0] rd_desc [pmem_cfg_pkg::num_iface],
	input  logic q_almost_full [pmem_cfg_pkg::num_iface],
	output logic q_push [pmem_cfg_pkg::num_iface],
	output logic [pmem_cmd_pkg::cmd_w-1:0] q_data
);

	logic take;
	// match waiting for its descriptor
	logic pend_valid;
	logic [pmem_cfg_pkg::iface_w-1:0] pend_in;
	logic [pmem_cfg_pkg::iface_w-1:0] pend_out;

	// any queue near full stops new matches
	// the free slot absorbs the command already in flight
	always_comb begin
		tagin_ready = 1'b1;
		for (int i = 0; i < pmem_cfg_pkg::num_iface; i++) begin
			if (q_almost_full[i]) begin
				tagin_ready = 1'b0;
			end
		end
	end

	assign take = tagin_valid && tagin_ready;

	// tag goes to all four tables at once
	assign rd_tag = tagin_data[pmem_cmd_pkg::match_tag_lsb +: pmem_cfg_pkg::tag_w];

	always_ff @(posedge clock) begin
		if (reset) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= take;
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			pend_in <= tagin_data[pmem_cmd_pkg::match_in_lsb +: pmem_cfg_pkg::iface_w];
			pend_out <= tagin_data[pmem_cmd_pkg::match_out_lsb +: pmem_cfg_pkg::iface_w];
		end
	end

	// pick the named input's descriptor
	assign q_data = {pend_in, rd_desc[pend_in]};

	// push into exactly one queue
	always_comb begin
		for (int i = 0; i < pmem_cfg_pkg::num_iface; i++) begin
			q_push[i] = pend_valid && (pend_out == i);
		end
	end

endmodule

// File: dispatch/cmd_queue.sv
`timescale 1ns/10ps

module cmd_queue (
	input  logic clock,
	input  logic reset,
	input  logic push,
	input  logic [pmem_cmd_pkg::cmd_w-1:0] push_data,
	input  logic pop,
	output logic [pmem_cmd_pkg::cmd_w-1:0] head,
	output logic empty,
	output logic almost_full
);

	logic [pmem_cmd_pkg::cmd_w-1:0] mem [pmem_cfg_pkg::cmdq_depth];
	logic [pmem_cfg_pkg::cmdq_ptr_w-1:0] wr_ptr;
	logic [pmem_cfg_pkg::cmdq_ptr_w-1:0] rd_ptr;
	// entries held, needs one more bit than the pointers
	logic [pmem_cfg_pkg::cmdq_ptr_w:0] count;

	// show-ahead, oldest entry always visible
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	// at most one free slot
	assign almost_full = (count >= pmem_cfg_pkg::cmdq_depth - 1);

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap on their own, depth is a power of two
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		push |-> (count < pmem_cfg_pkg::cmdq_depth));

	a_no_underflow: assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty);

endmodule

// File: source/egress_reader.sv
`timescale 1ns/10ps

module egress_reader (
	input  logic clock,
	input  logic reset,
	input  logic [pmem_cmd_pkg::cmd_w-1:0] q_head,
	input  logic q_empty,
	output logic q_pop,
	output logic [pmem_cfg_pkg::addr_w-1:0] rd_addr [pmem_cfg_pkg::num_iface],
	input  logic [pmem_cfg_pkg::data_w-1:0] rd_data [pmem_cfg_pkg::num_iface],
	output logic [pmem_cfg_pkg::data_w-1:0] tx_data,
	output logic tx_valid,
	output logic tx_sop,
	output logic tx_eop,
	output logic [pmem_cfg_pkg::empty_w-1:0] tx_empty,
	input  logic tx_ready
);

	pmem_cmd_pkg::egress_state_t state;
	// input whose store is being read
	logic [pmem_cfg_pkg::iface_w-1:0] src_q;
	// next beat address
	logic [pmem_cfg_pkg::addr_w-1:0] addr_q;
	// beats still to send
	logic [pmem_cfg_pkg::len_w-1:0] remain_q;
	logic [pmem_cfg_pkg::empty_w-1:0] pkt_empty_q;
	logic out_adv;
	logic beat_go;
	logic last_beat;

	// head is already valid, take it in the pop cycle
	assign q_pop = (state == pmem_cmd_pkg::idle) && !q_empty;

	// output register free or draining
	assign out_adv = !tx_valid || tx_ready;
	// a beat moves into the output register in load and stream
	assign beat_go = (state != pmem_cmd_pkg::idle) && out_adv;
	assign last_beat = (remain_q == 1'b1);

	// same address to every store, the source mux picks the one we want
	always_comb begin
		for (int i = 0; i < pmem_cfg_pkg::num_iface; i++) begin
			rd_addr[i] = addr_q;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= pmem_cmd_pkg::idle;
			src_q <= '0;
			addr_q <= '0;
			remain_q <= '0;
		end else begin
			case (state)
				pmem_cmd_pkg::idle: begin
					if (q_pop) begin
						src_q <= q_head[pmem_cmd_pkg::cmd_in_lsb +: pmem_cfg_pkg::iface_w];
						addr_q <= q_head[pmem_cmd_pkg::desc_addr_lsb +: pmem_cfg_pkg::addr_w];
						remain_q <= q_head[pmem_cmd_pkg::desc_len_lsb +: pmem_cfg_pkg::len_w];
						state <= pmem_cmd_pkg::load;
					end
				end
				pmem_cmd_pkg::load, pmem_cmd_pkg::stream: begin
					if (out_adv) begin
						// wraps at the end of the store
						addr_q <= addr_q + 1'b1;
						remain_q <= remain_q - 1'b1;
						state <= last_beat ? pmem_cmd_pkg::idle : pmem_cmd_pkg::stream;
					end
				end
				default: state <= pmem_cmd_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tx_valid <= 1'b0;
		end else if (beat_go) begin
			tx_valid <= 1'b1;
		end else if (out_adv) begin
			tx_valid <= 1'b0;
		end
	end

	// payload of the output register, held while stalled
	always_ff @(posedge clock) begin
		if (q_pop) begin
			pkt_empty_q <= q_head[pmem_cmd_pkg::desc_empty_lsb +: pmem_cfg_pkg::empty_w];
		end
		if (beat_go) begin
			tx_data <= rd_data[src_q];
			// first beat always leaves from load
			tx_sop <= (state == pmem_cmd_pkg::load);
			tx_eop <= last_beat;
			tx_empty <= last_beat ? pkt_empty_q : '0;
		end
	end

	a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
		(tx_valid && !tx_ready) |=>
		(tx_valid && $stable(tx_data) && $stable(tx_sop) && $stable(tx_eop)
			&& $stable(tx_empty)));

endmodule

// File: source/pmem_group.sv
`timescale 1ns/10ps

module pmem_group (
	input  logic clock,
	input  logic reset,

	// streams from the interfaces
	input  logic [pmem_cfg_pkg::data_w-1:0] packetin_data [pmem_cfg_pkg::num_iface],
	input  logic packetin_valid [pmem_cfg_pkg::num_iface],
	input  logic packetin_sop [pmem_cfg_pkg::num_iface],
	input  logic packetin_eop [pmem_cfg_pkg::num_iface],
	output logic packetin_ready [pmem_cfg_pkg::num_iface],
	input  logic [pmem_cfg_pkg::empty_w-1:0] packetin_empty [pmem_cfg_pkg::num_iface],

	// same streams with the tag in front
	output logic [pmem_cfg_pkg::tag_w+pmem_cfg_pkg::data_w-1:0]
		packetout_data [pmem_cfg_pkg::num_iface],
	output logic packetout_valid [pmem_cfg_pkg::num_iface],
	output logic packetout_sop [pmem_cfg_pkg::num_iface],
	output logic packetout_eop [pmem_cfg_pkg::num_iface],
	input  logic packetout_ready [pmem_cfg_pkg::num_iface],

	// stored packets going out
	output logic [pmem_cfg_pkg::data_w-1:0] transmitout_data [pmem_cfg_pkg::num_iface],
	output logic transmitout_valid [pmem_cfg_pkg::num_iface],
	output logic transmitout_sop [pmem_cfg_pkg::num_iface],
	output logic transmitout_eop [pmem_cfg_pkg::num_iface],
	output logic [pmem_cfg_pkg::empty_w-1:0] transmitout_empty [pmem_cfg_pkg::num_iface],
	input  logic transmitout_ready [pmem_cfg_pkg::num_iface],

	// match results
	input  logic [pmem_cmd_pkg::match_w-1:0] tagin_data,
	input  logic tagin_valid,
	output logic tagin_ready
);

	localparam int n = pmem_cfg_pkg::num_iface;

	// ingress side, per input
	logic [pmem_cfg_pkg::tag_w-1:0] tag [n];
	logic wr_en [n];
	logic [pmem_cfg_pkg::addr_w-1:0] wr_addr [n];
	logic desc_wr [n];
	logic [pmem_cmd_pkg::desc_w-1:0] desc_data [n];

	// store read ports, indexed [input][output] and [output][input]
	logic [pmem_cfg_pkg::addr_w-1:0] store_rd_addr [n][n];
	logic [pmem_cfg_pkg::data_w-1:0] store_rd_data [n][n];
	logic [pmem_cfg_pkg::addr_w-1:0] egress_rd_addr [n][n];
	logic [pmem_cfg_pkg::data_w-1:0] egress_rd_data [n][n];

	// dispatch and queues
	logic [pmem_cfg_pkg::tag_w-1:0] rd_tag;
	logic [pmem_cmd_pkg::desc_w-1:0] rd_desc [n];
	logic q_push [n];
	logic [pmem_cmd_pkg::cmd_w-1:0] q_data;
	logic q_pop [n];
	logic [pmem_cmd_pkg::cmd_w-1:0] q_head [n];
	logic q_empty [n];
	logic q_almost_full [n];

	match_dispatch u_dispatch (
		.clock(clock),
		.reset(reset),
		.tagin_data(tagin_data),
		.tagin_valid(tagin_valid),
		.tagin_ready(tagin_ready),
		.rd_tag(rd_tag),
		.rd_desc(rd_desc),
		.q_almost_full(q_almost_full),
		.q_push(q_push),
		.q_data(q_data)
	);

	for (genvar i = 0; i < n; i++) begin : g_iface
		// passthrough, ready comes straight back
		assign packetin_ready[i] = packetout_ready[i];
		assign packetout_valid[i] = packetin_valid[i];
		assign packetout_sop[i] = packetin_sop[i];
		assign packetout_eop[i] = packetin_eop[i];
		assign packetout_data[i] = {tag[i], packetin_data[i]};

		// cross the read ports between stores and readers
		for (genvar j = 0; j < n; j++) begin : g_xbar
			assign store_rd_addr[i][j] = egress_rd_addr[j][i];
			assign egress_rd_data[i][j] = store_rd_data[j][i];
		end

		ingress_tagger u_tagger (
			.clock(clock),
			.reset(reset),
			.in_valid(packetin_valid[i]),
			.in_ready(packetout_ready[i]),
			.in_sop(packetin_sop[i]),
			.in_eop(packetin_eop[i]),
			.in_empty(packetin_empty[i]),
			.tag(tag[i]),
			.wr_en(wr_en[i]),
			.wr_addr(wr_addr[i]),
			.desc_wr(desc_wr[i]),
			.desc_data(desc_data[i])
		);

		packet_store u_store (
			.clock(clock),
			.wr_en(wr_en[i]),
			.wr_addr(wr_addr[i]),
			.wr_data(packetin_data[i]),
			.rd_addr(store_rd_addr[i]),
			.rd_data(store_rd_data[i])
		);

		packet_table u_table (
			.clock(clock),
			.wr_en(desc_wr[i]),
			.wr_tag(tag[i]),
			.wr_desc(desc_data[i]),
			.rd_tag(rd_tag),
			.rd_desc(rd_desc[i])
		);

		cmd_queue u_cmdq (
			.clock(clock),
			.reset(reset),
			.push(q_push[i]),
			.push_data(q_data),
			.pop(q_pop[i]),
			.head(q_head[i]),
			.empty(q_empty[i]),
			.almost_full(q_almost_full[i])
		);

		egress_reader u_egress (
			.clock(clock),
			.reset(reset),
			.q_head(q_head[i]),
			.q_empty(q_empty[i]),
			.q_pop(q_pop[i]),
			.rd_addr(egress_rd_addr[i]),
			.rd_data(egress_rd_data[i]),
			.tx_data(transmitout_data[i]),
			.tx_valid(transmitout_valid[i]),
			.tx_sop(transmitout_sop[i]),
			.tx_eop(transmitout_eop[i]),
			.tx_empty(transmitout_empty[i]),
			.tx_ready(transmitout_ready[i])
		);
	end

endmodule

// File: sim/pmem_group_tb.sv
`timescale 1ns/10ps

module pmem_group_tb;

	localparam int n = pmem_cfg_pkg::num_iface;
	localparam int dw = pmem_cfg_pkg::data_w;
	localparam int ew = pmem_cfg_pkg::empty_w;
	localparam int tw = pmem_cfg_pkg::tag_w;
	localparam int iw = pmem_cfg_pkg::iface_w;
	localparam int max_len = 8;
	// packets per input, enough to wrap the tags and the store addresses
	localparam int num_packets = 200;
	localparam int max_beats_out = 100;
	localparam int max_tags_out = 24;
	// every beat may wait behind a stalled output and a full queue
	localparam int cycle_limit = num_packets * max_len * 25;
	// idle cycles after the last packet, long enough for a repeated packet to start
	localparam int drain_cycles = 16;

	logic clock;
	logic reset;
	logic [dw-1:0] packetin_data [n];
	logic packetin_valid [n];
	logic packetin_sop [n];
	logic packetin_eop [n];
	logic packetin_ready [n];
	logic [ew-1:0] packetin_empty [n];
	logic [tw+dw-1:0] packetout_data [n];
	logic packetout_valid [n];
	logic packetout_sop [n];
	logic packetout_eop [n];
	logic packetout_ready [n];
	logic [dw-1:0] transmitout_data [n];
	logic transmitout_valid [n];
	logic transmitout_sop [n];
	logic transmitout_eop [n];
	logic [ew-1:0] transmitout_empty [n];
	logic transmitout_ready [n];
	logic [pmem_cmd_pkg::match_w-1:0] tagin_data;
	logic tagin_valid;
	logic tagin_ready;

	logic [15:0] lfsr;
	// model of each input, packets by tag
	logic [dw-1:0] exp_data [n][pmem_cfg_pkg::tag_depth][max_len];
	int exp_len [n][pmem_cfg_pkg::tag_depth];
	logic [ew-1:0] exp_empty [n][pmem_cfg_pkg::tag_depth];
	logic [iw-1:0] exp_dest [n][pmem_cfg_pkg::tag_depth];
	logic [tw-1:0] model_tag [n];
	// packet being driven on each input
	int left [n];
	int beat_in [n];
	int started [n];
	int beats_out [n];
	int tags_out [n];
	bit in_taken [n];
	bit tag_taken;
	// finished packets waiting for their match, {output, input, tag}
	logic [pmem_cmd_pkg::match_w-1:0] match_q [$];
	// expected packets per output in order, {input, tag}
	logic [iw+tw-1:0] exp_pkt [n][n*num_packets];
	int exp_wr [n];
	int exp_rd [n];
	int beat_out [n];
	// output values seen while stalled
	bit held [n];
	logic [dw-1:0] hold_data [n];
	logic hold_sop [n];
	logic hold_eop [n];
	logic [ew-1:0] hold_empty [n];
	int done;
	int cycles;

	pmem_group UUT (
		.clock(clock),
		.reset(reset),
		.packetin_data(packetin_data),
		.packetin_valid(packetin_valid),
		.packetin_sop(packetin_sop),
		.packetin_eop(packetin_eop),
		.packetin_ready(packetin_ready),
		.packetin_empty(packetin_empty),
		.packetout_data(packetout_data),
		.packetout_valid(packetout_valid),
		.packetout_sop(packetout_sop),
		.packetout_eop(packetout_eop),
		.packetout_ready(packetout_ready),
		.transmitout_data(transmitout_data),
		.transmitout_valid(transmitout_valid),
		.transmitout_sop(transmitout_sop),
		.transmitout_eop(transmitout_eop),
		.transmitout_empty(transmitout_empty),
		.transmitout_ready(transmitout_ready),
		.tagin_data(tagin_data),
		.tagin_valid(tagin_valid),
		.tagin_ready(tagin_ready)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [63:0] rand_bits(input int width);
		logic [63:0] r;
		logic fb;
		r = '0;
		for (int k = 0; k < width; k++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[62:0], fb};
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] want);
		$display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic drive_inputs();
		logic [tw-1:0] t;
		for (int i = 0; i < n; i++) begin
			// a beat not yet taken stays on the bus
			if (!(packetin_valid[i] && !in_taken[i])) begin
				packetin_valid[i] = 1'b0;
				packetin_sop[i] = 1'b0;
				packetin_eop[i] = 1'b0;
				packetin_empty[i] = '0;
				t = model_tag[i];
				if (left[i] == 0 && started[i] < num_packets && tags_out[i] < max_tags_out
						&& beats_out[i] + max_len <= max_beats_out && rand_bits(1)) begin
					left[i] = rand_bits(3) + 1;
					beat_in[i] = 0;
					exp_len[i][t] = left[i];
					exp_empty[i][t] = rand_bits(ew);
					exp_dest[i][t] = rand_bits(iw);
					started[i]++;
					tags_out[i]++;
					beats_out[i] += left[i];
				end
				if (left[i] > 0) begin
					packetin_valid[i] = 1'b1;
					packetin_data[i] = rand_bits(dw);
					packetin_sop[i] = (beat_in[i] == 0);
					packetin_eop[i] = (left[i] == 1);
					packetin_empty[i] = (left[i] == 1) ? exp_empty[i][t] : '0;
					exp_data[i][t][beat_in[i]] = packetin_data[i];
					beat_in[i]++;
					left[i]--;
				end
			end
			packetout_ready[i] = (rand_bits(2) != 0);
			transmitout_ready[i] = (rand_bits(2) != 0);
		end
		// match held until tagin_ready
		if (!(tagin_valid && !tag_taken)) begin
			tagin_valid = 1'b0;
			if (match_q.size() > 0) begin
				tagin_data = match_q.pop_front();
				tagin_valid = 1'b1;
			end
		end
	endtask

	task automatic sample_outputs();
		logic [iw-1:0] idx;
		logic [iw-1:0] dest;
		logic [iw-1:0] src;
		logic [tw-1:0] t;
		logic [iw+tw-1:0] pkt;
		bit last;
		for (int i = 0; i < n; i++) begin
			idx = i;
			// passthrough follows the interface on every cycle
			assert (packetin_ready[i] === packetout_ready[i])
				else report_mismatch($sformatf("packetin_ready[%0d]", i),
					packetin_ready[i], packetout_ready[i]);
			assert (packetout_valid[i] === packetin_valid[i])
				else report_mismatch($sformatf("packetout_valid[%0d]", i),
					packetout_valid[i], packetin_valid[i]);
			assert (packetout_sop[i] === packetin_sop[i])
				else report_mismatch($sformatf("packetout_sop[%0d]", i),
					packetout_sop[i], packetin_sop[i]);
			assert (packetout_eop[i] === packetin_eop[i])
				else report_mismatch($sformatf("packetout_eop[%0d]", i),
					packetout_eop[i], packetin_eop[i]);
			in_taken[i] = packetin_valid[i] && packetin_ready[i];
			if (in_taken[i]) begin
				assert (packetout_data[i] === {model_tag[i], packetin_data[i]})
					else report_mismatch($sformatf("packetout_data[%0d]", i),
						packetout_data[i], {model_tag[i], packetin_data[i]});
				if (packetin_eop[i]) begin
					match_q.push_back({exp_dest[i][model_tag[i]], idx, model_tag[i]});
					model_tag[i]++;
				end
			end
		end
		tag_taken = tagin_valid && tagin_ready;
		if (tag_taken) begin
			dest = tagin_data[pmem_cmd_pkg::match_out_lsb +: iw];
			exp_pkt[dest][exp_wr[dest]] = tagin_data[pmem_cmd_pkg::match_tag_lsb +: iw+tw];
			exp_wr[dest]++;
		end
		for (int o = 0; o < n; o++) begin
			// stalled last cycle, must not have moved
			if (held[o]) begin
				assert (transmitout_valid[o] === 1'b1)
					else report_mismatch($sformatf("transmitout_valid[%0d]", o),
						transmitout_valid[o], 1);
				assert (transmitout_data[o] === hold_data[o])
					else report_mismatch($sformatf("transmitout_data[%0d]", o),
						transmitout_data[o], hold_data[o]);
				assert ({transmitout_sop[o], transmitout_eop[o], transmitout_empty[o]}
						=== {hold_sop[o], hold_eop[o], hold_empty[o]})
					else report_mismatch($sformatf("transmitout_sop_eop_empty[%0d]", o),
						{transmitout_sop[o], transmitout_eop[o], transmitout_empty[o]},
						{hold_sop[o], hold_eop[o], hold_empty[o]});
			end
			if (transmitout_valid[o] && transmitout_ready[o]) begin
				assert (exp_rd[o] < exp_wr[o])
					else report_failure($sformatf("output %0d sent a beat with no packet due", o));
				pkt = exp_pkt[o][exp_rd[o]];
				src = pkt[tw +: iw];
				t = pkt[0 +: tw];
				last = (beat_out[o] == exp_len[src][t] - 1);
				assert (transmitout_data[o] === exp_data[src][t][beat_out[o]])
					else report_mismatch($sformatf("transmitout_data[%0d]", o),
						transmitout_data[o], exp_data[src][t][beat_out[o]]);
				assert (transmitout_sop[o] === (beat_out[o] == 0))
					else report_mismatch($sformatf("transmitout_sop[%0d]", o),
						transmitout_sop[o], beat_out[o] == 0);
				assert (transmitout_eop[o] === last)
					else report_mismatch($sformatf("transmitout_eop[%0d]", o),
						transmitout_eop[o], last);
				assert (transmitout_empty[o] === (last ? exp_empty[src][t] : '0))
					else report_mismatch($sformatf("transmitout_empty[%0d]", o),
						transmitout_empty[o], last ? exp_empty[src][t] : '0);
				if (last) begin
					// packet out, frees its tag and store space
					exp_rd[o]++;
					beat_out[o] = 0;
					tags_out[src]--;
					beats_out[src] -= exp_len[src][t];
					done++;
				end else begin
					beat_out[o]++;
				end
			end
			held[o] = transmitout_valid[o] && !transmitout_ready[o];
			hold_data[o] = transmitout_data[o];
			hold_sop[o] = transmitout_sop[o];
			hold_eop[o] = transmitout_eop[o];
			hold_empty[o] = transmitout_empty[o];
		end
	endtask

	// one clock of stimulus and checking
	task automatic run_cycle();
		@(posedge clock);
		#1;
		drive_inputs();
		@(negedge clock);
		sample_outputs();
	endtask

	initial begin
		lfsr = 16'd18745;
		reset = 1'b1;
		tagin_data = '0;
		tagin_valid = 1'b0;
		tag_taken = 1'b0;
		done = 0;
		for (int i = 0; i < n; i++) begin
			packetin_data[i] = '0;
			packetin_valid[i] = 1'b0;
			packetin_sop[i] = 1'b0;
			packetin_eop[i] = 1'b0;
			packetin_empty[i] = '0;
			packetout_ready[i] = 1'b0;
			transmitout_ready[i] = 1'b0;
			model_tag[i] = '0;
			left[i] = 0;
			beat_in[i] = 0;
			started[i] = 0;
			beats_out[i] = 0;
			tags_out[i] = 0;
			in_taken[i] = 1'b0;
			exp_wr[i] = 0;
			exp_rd[i] = 0;
			beat_out[i] = 0;
			held[i] = 1'b0;
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		// state right after reset
		@(negedge clock);
		for (int o = 0; o < n; o++) begin
			assert (transmitout_valid[o] === 1'b0)
				else report_mismatch($sformatf("transmitout_valid[%0d]", o),
					transmitout_valid[o], 0);
		end
		assert (tagin_ready === 1'b1)
			else report_mismatch("tagin_ready", tagin_ready, 1);
		while (done < n * num_packets) begin
			run_cycle();
		end
		// a repeated packet shows up as a beat with nothing due
		repeat (drain_cycles) begin
			run_cycle();
		end
		$display("All checks passed");
		$finish;
	end

	// run length limit
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d packets delivered", cycles, done);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

// File: flist.f
common/pmem_cfg_pkg.sv
common/pmem_cmd_pkg.sv
source/ingress_tagger.sv
packet_buffer/packet_store.sv
packet_buffer/packet_table.sv
dispatch/match_dispatch.sv
dispatch/cmd_queue.sv
source/egress_reader.sv
source/pmem_group.sv
sim/pmem_group_tb.sv

// File: Bender.yml
package:
  name: pmem_group

sources:
  - common/pmem_cfg_pkg.sv
  - common/pmem_cmd_pkg.sv
  - source/ingress_tagger.sv
  - packet_buffer/packet_store.sv
  - packet_buffer/packet_table.sv
  - dispatch/match_dispatch.sv
  - dispatch/cmd_queue.sv
  - source/egress_reader.sv
  - source/pmem_group.sv
  - target: simulation
    files:
      - sim/pmem_group_tb.sv
